// ==== run_sim.sh ====
#!/bin/sh
# build and run the kernel loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_kernel_loader -f sim.f -o sim_kernel_loader

# the log decides pass or fail
./obj_dir/sim_kernel_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== sim.f ====
verilog/kl_pkg.sv
verilog/tile_geometry.sv
verilog/tile_sequencer.sv
verilog/icb_column_reader.sv
verilog/weight_tile_buffer.sv
verilog/kernel_loader.sv
sim/icb_mem_model.sv
sim/tb_kernel_loader.sv

// ==== sim/icb_mem_model.sv ====
`timescale 1ns/100ps

module icb_mem_model #(
  parameter int BUS_WIDTH = 32,
  parameter int addr_w    = 16   // 64 KiB byte space, upper address bits ignored
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,          // random back-pressure from testbench
  input  logic                 icb_cmd_valid,
  output logic                 icb_cmd_ready,
  input  logic [31:0]          icb_cmd_addr,
  input  logic [3:0]           icb_cmd_len,    // beats - 1
  output logic                 icb_rsp_valid,
  input  logic                 icb_rsp_ready,
  output logic [BUS_WIDTH-1:0] icb_rsp_rdata
);

  localparam int bpb = BUS_WIDTH / 8;  // bytes per beat

  logic [7:0]        mem [2**addr_w];  // filled by the testbench at time 0
  logic [addr_w-1:0] rd_addr;          // address of the beat on the bus
  logic [4:0]        beats_left;       // up to 16

  // one burst in flight, so responses stay in command order
  assign icb_cmd_ready = !icb_rsp_valid && !stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      icb_rsp_valid <= 1'b0;
      rd_addr       <= '0;
      beats_left    <= '0;
    end else if (icb_cmd_valid && icb_cmd_ready) begin
      icb_rsp_valid <= 1'b1;
      rd_addr       <= icb_cmd_addr[addr_w-1:0];
      beats_left    <= {1'b0, icb_cmd_len} + 5'd1;
    end else if (icb_rsp_valid && icb_rsp_ready) begin
      rd_addr    <= rd_addr + addr_w'(bpb);  // next beat
      beats_left <= beats_left - 5'd1;
      if (beats_left == 5'd1) icb_rsp_valid <= 1'b0;  // burst done
    end
  end

  // byte 0 = lowest address
  for (genvar b = 0; b < bpb; b++) begin : gen_byte
    assign icb_rsp_rdata[b*8 +: 8] = mem[rd_addr + addr_w'(b)];
  end

endmodule

// ==== sim/tb_kernel_loader.sv ====
`timescale 1ns/100ps

module tb_kernel_loader import kl_pkg::*; ();

  localparam int          SIZE       = 16;
  localparam int          BUS_WIDTH  = 32;
  localparam int          clk_period = 20;
  localparam int          mem_aw     = 16;
  localparam logic [31:0] seed       = 32'h10143b60;

  // row tiles x column tiles x repeats
  function automatic int tile_count(input int k, input int n, input int m);
    return ((n + SIZE - 1) / SIZE) * ((m + SIZE - 1) / SIZE) * ((k + SIZE - 1) / SIZE);
  endfunction

  localparam int total_tiles = tile_count(16, 32, 48) + tile_count(5, 20, 37)
                             + tile_count(40, 24, 20) + tile_count(16, 16, 16)
                             + tile_count(20, 48, 30);
  localparam int watchdog_ns = 50 * total_tiles * (SIZE + 40) * clk_period;

  logic                   clk;
  logic                   rst_n;
  logic                   init_cfg;
  kl_cfg_t                cfg;
  logic                   load_weight_req;
  logic                   load_weight_granted = 1'b0;
  logic                   send_weight_trigger = 1'b0;
  logic                   stall = 1'b0;
  logic                   icb_cmd_valid;
  logic                   icb_cmd_ready;
  logic [31:0]            icb_cmd_addr;
  logic [3:0]             icb_cmd_len;
  logic                   icb_rsp_valid;
  logic                   icb_rsp_ready;
  logic [BUS_WIDTH-1:0]   icb_rsp_rdata;
  logic                   weight_row_valid;
  logic [SIZE*8-1:0]      weight_out;
  logic                   weight_sending_done;
  logic                   weight_data_valid;

  logic [31:0] rng_stall = seed ^ 32'h5a5a0001;  // one stream per process
  logic [31:0] rng_grant = seed ^ 32'h00c3a502;
  logic [31:0] rng_trig  = seed ^ 32'h3c000f03;

  logic [31:0] cur_n;       // active config as the reference sees it
  logic [31:0] cur_m;
  logic [31:0] cur_base;
  logic [31:0] cur_stride;
  logic [7:0]  cur_zp;
  int          cur_row_tiles;
  int          cur_col_tiles;
  int          cur_loops;

  int   exp_rt = 0;      // expected tile indices
  int   exp_ct = 0;
  int   exp_loop = 0;
  int   rows_seen = 0;
  int   cyc = 0;
  int   trig_cyc = 0;
  int   done_count = 0;
  int   errors = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  int   grant_wait = 0;
  int   trig_wait = 0;
  logic cfg_seen = 1'b0;

  kernel_loader #(.SIZE(SIZE), .BUS_WIDTH(BUS_WIDTH)) uut (
    .clk, .rst_n, .init_cfg, .cfg, .load_weight_req, .load_weight_granted,
    .send_weight_trigger, .icb_cmd_valid, .icb_cmd_ready, .icb_cmd_addr, .icb_cmd_len,
    .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata, .weight_row_valid, .weight_out,
    .weight_sending_done, .weight_data_valid
  );

  icb_mem_model #(.BUS_WIDTH(BUS_WIDTH), .addr_w(mem_aw)) u_mem (
    .clk, .rst_n, .stall, .icb_cmd_valid, .icb_cmd_ready, .icb_cmd_addr, .icb_cmd_len,
    .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata
  );

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // column-major weights, zero point added mod 256, padding is zero
  function automatic logic [7:0] expected_lane(
    input logic [31:0] n, input logic [31:0] m, input logic [31:0] base,
    input logic [31:0] stride, input logic [7:0] zp,
    input int rt, input int ct, input int row, input int lane);
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] a;
    r = 32'(rt * SIZE + row);
    c = 32'(ct * SIZE + lane);
    if (r >= n || c >= m) return 8'h00;
    a = base + c * stride + r;
    return u_mem.mem[a[mem_aw-1:0]] + zp;
  endfunction

  task automatic report(input string name, input int first_err);
    if (errors == first_err) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, errors - first_err);
    end
  endtask

  // ========================================
  // clock, watchdog, memory stalls
  // ========================================
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("run timed out after %0d ns, %0d tiles done in current test", watchdog_ns,
             done_count);
    $display("Result: FAILED");
    $finish;
  end

  always @(posedge clk) begin
    rng_stall = xorshift(rng_stall);
    stall <= (rng_stall[1:0] == 2'b00);  // about 1 in 4 cycles
  end

  // ========================================
  // array controller side
  // ========================================
  always @(posedge clk) begin
    load_weight_granted <= 1'b0;
    if (load_weight_req && !load_weight_granted) begin
      if (grant_wait == 0) begin
        load_weight_granted <= 1'b1;
        rng_grant = xorshift(rng_grant);
        grant_wait <= int'(rng_grant % 6);  // 0..5 for the next one
      end else begin
        grant_wait <= grant_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    send_weight_trigger <= 1'b0;
    if (!weight_data_valid) begin
      rng_trig = xorshift(rng_trig);
      trig_wait <= int'(rng_trig % 3);
    end else if (!send_weight_trigger) begin
      if (trig_wait == 0) send_weight_trigger <= 1'b1;  // lands 1..3 after valid
      else trig_wait <= trig_wait - 1;
    end
  end

  // ========================================
  // comparator
  // ========================================
  always @(posedge clk) begin : compare
    int         row;
    logic [7:0] exp_b;
    logic [7:0] got_b;
    cyc = cyc + 1;
    if (init_cfg) begin  // new config, walk restarts
      cfg_seen   = 1'b1;
      exp_rt     = 0;
      exp_ct     = 0;
      exp_loop   = 0;
      done_count = 0;
    end
    if (icb_cmd_valid && !cfg_seen) begin
      $display("ERROR at %0t: ICB command issued before any init_cfg", $time);
      errors++;
    end
    if (send_weight_trigger && weight_data_valid) begin
      trig_cyc  = cyc;
      rows_seen = 0;
    end
    if (weight_row_valid) begin
      if (cyc != trig_cyc + 1 + rows_seen) begin
        $display("CHECK FAILED at %0t: row %0d of tile %0d/%0d out of step with trigger",
                 $time, rows_seen, exp_rt, exp_ct);
        errors++;
      end
      row = SIZE - 1 - rows_seen;  // last row first
      for (int lane = 0; lane < SIZE; lane++) begin
        exp_b = expected_lane(cur_n, cur_m, cur_base, cur_stride, cur_zp,
                              exp_rt, exp_ct, row, lane);
        got_b = weight_out[lane*8 +: 8];
        if (got_b != exp_b) begin
          $display("CHECK FAILED at %0t: tile rt %0d ct %0d loop %0d row %0d lane %0d got %h exp %h",
                   $time, exp_rt, exp_ct, exp_loop, row, lane, got_b, exp_b);
          errors++;
        end
      end
      rows_seen++;
    end
    if (weight_sending_done) begin
      if (rows_seen != SIZE || cyc != trig_cyc + SIZE + 1) begin
        $display("CHECK FAILED at %0t: done after %0d rows, %0d cycles from trigger",
                 $time, rows_seen, cyc - trig_cyc);
        errors++;
      end
      done_count++;
      if (exp_rt < cur_row_tiles - 1) begin  // row tile inner
        exp_rt++;
      end else begin
        exp_rt = 0;
        if (exp_ct < cur_col_tiles - 1) begin
          exp_ct++;
        end else begin
          exp_ct = 0;
          exp_loop++;
        end
      end
    end
  end

  // one full configuration, then check the loader goes quiet
  task automatic run_config(input string name, input int k, input int n, input int m,
                            input logic [31:0] base, input logic [31:0] stride,
                            input logic [31:0] zp);
    int first_err;
    int tiles;
    first_err = errors;
    tiles     = tile_count(k, n, m);
    @(posedge clk);
    cur_n         = 32'(n);
    cur_m         = 32'(m);
    cur_base      = base;
    cur_stride    = stride;
    cur_zp        = zp[7:0];  // only low byte counts
    cur_row_tiles = (n + SIZE - 1) / SIZE;
    cur_col_tiles = (m + SIZE - 1) / SIZE;
    cur_loops     = (k + SIZE - 1) / SIZE;
    init_cfg       <= 1'b1;
    cfg.k          <= 32'(k);
    cfg.n          <= 32'(n);
    cfg.m          <= 32'(m);
    cfg.zero_point <= zp;
    cfg.col_stride <= stride;
    cfg.base       <= base;
    @(posedge clk);
    init_cfg <= 1'b0;
    do @(posedge clk); while (done_count < tiles);
    repeat (40) begin
      @(posedge clk);
      if (load_weight_req || icb_cmd_valid || weight_data_valid) begin
        $display("ERROR at %0t: loader still active after its %0d tiles", $time, tiles);
        errors++;
      end
    end
    if (exp_loop != cur_loops || done_count != tiles) begin
      $display("ERROR at %0t: %0d loops and %0d tiles seen, %0d and %0d expected",
               $time, exp_loop, done_count, cur_loops, tiles);
      errors++;
    end
    report(name, first_err);
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin : main
    logic [31:0] fill;
    int          first_err;
    rst_n    = 1'b0;
    init_cfg = 1'b0;
    cfg      = '0;
    fill     = seed;
    for (int a = 0; a < 2**mem_aw; a++) begin  // xorshift chain over all addresses
      fill = xorshift(fill);
      u_mem.mem[a] = fill[7:0];
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    first_err = errors;
    repeat (6) begin
      @(posedge clk);
      if (load_weight_req || icb_cmd_valid || icb_rsp_ready || weight_row_valid
          || weight_sending_done || weight_data_valid) begin
        $display("CHECK FAILED at %0t: control output high after reset", $time);
        errors++;
      end
    end
    report("reset", first_err);

    run_config("full tiles", 16, 32, 48, 32'h0000_0100, 32'd32, 32'h0000_017f);
    run_config("partial tiles", 5, 20, 37, 32'h0000_2003, 32'd24, 32'h0000_00f0);
    run_config("sequence and repeat", 40, 24, 20, 32'h0000_3000, 32'd40, 32'h0000_0003);
    run_config("send timing", 16, 16, 16, 32'h0000_5000, 32'd16, 32'h0000_0011);
    run_config("second configuration", 20, 48, 30, 32'h0000_8000, 32'd48, 32'h0000_0080);

    $display("tests passed %0d, failed %0d, check errors %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/icb_column_reader.sv ====
`timescale 1ns/100ps

module icb_column_reader import kl_pkg::*; #(
  parameter int SIZE      = 16,
  parameter int BUS_WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_start,
  input  tile_job_t                job,
  input  logic [reg_width-1:0]     stride,
  // icb command
  output logic                     icb_cmd_valid,
  input  logic                     icb_cmd_ready,
  output logic [reg_width-1:0]     icb_cmd_addr,
  output logic [icb_len_w-1:0]     icb_cmd_len,
  // icb response
  input  logic                     icb_rsp_valid,
  output logic                     icb_rsp_ready,
  input  logic [BUS_WIDTH-1:0]     icb_rsp_rdata,
  // buffer side
  output logic                     tile_loaded,
  output logic                     wr_en,
  output logic [$clog2(SIZE)-1:0]  wr_col,
  output logic [$clog2(SIZE)-1:0]  wr_row,
  output logic [BUS_WIDTH-1:0]     wr_data
);

  localparam int idx_w  = $clog2(SIZE);
  localparam int bpb    = BUS_WIDTH / byte_w;  // bytes per beat
  localparam int lg_bpb = $clog2(bpb);

  logic [icb_len_w-1:0] beats_m1;  // beats per column - 1
  logic [15:0]          cols_m1;
  logic [idx_w-1:0]     cmd_col;   // columns issued
  logic [icb_len_w-1:0] rsp_beat;  // beat within column
  logic [idx_w-1:0]     rsp_col;   // column being returned
  logic                 cmd_hs;
  logic                 rsp_hs;
  logic                 last_beat;
  logic                 last_rsp_col;

  // ceil(rows / bytes per beat), add and shift
  assign beats_m1 = icb_len_w'(((job.rows + 16'(bpb - 1)) >> lg_bpb) - 16'd1);
  assign cols_m1  = job.cols - 16'd1;

  assign cmd_hs      = icb_cmd_valid && icb_cmd_ready;
  assign rsp_hs      = icb_rsp_valid && icb_rsp_ready;
  assign icb_cmd_len = beats_m1;  // job held for the whole load

  // ======================================
  // command side, one burst per column
  // ======================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      icb_cmd_valid <= 1'b0;
      icb_cmd_addr  <= '0;
      cmd_col       <= '0;
    end else if (load_start) begin
      icb_cmd_valid <= 1'b1;
      icb_cmd_addr  <= job.addr;
      cmd_col       <= '0;
    end else if (cmd_hs) begin
      if (16'(cmd_col) == cols_m1) begin
        icb_cmd_valid <= 1'b0;  // last column accepted
      end else begin
        icb_cmd_addr <= icb_cmd_addr + stride;  // next column
        cmd_col      <= cmd_col + 1'b1;
      end
    end
  end

  // ======================================
  // response side, in-order beat count
  // ======================================
  assign last_beat    = (rsp_beat == beats_m1);
  assign last_rsp_col = (16'(rsp_col) == cols_m1);
  assign tile_loaded  = rsp_hs && last_beat && last_rsp_col;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      icb_rsp_ready <= 1'b0;
      rsp_beat      <= '0;
      rsp_col       <= '0;
    end else if (load_start) begin
      icb_rsp_ready <= 1'b1;  // held for whole load, no back-pressure
      rsp_beat      <= '0;
      rsp_col       <= '0;
    end else if (rsp_hs) begin
      if (last_beat) begin
        rsp_beat <= '0;
        if (last_rsp_col) begin
          icb_rsp_ready <= 1'b0;
        end else begin
          rsp_col <= rsp_col + 1'b1;
        end
      end else begin
        rsp_beat <= rsp_beat + 1'b1;
      end
    end
  end

  // beat -> column and first row, tail bytes masked later
  assign wr_en   = rsp_hs;
  assign wr_col  = rsp_col;
  assign wr_row  = idx_w'(32'(rsp_beat) << lg_bpb);
  assign wr_data = icb_rsp_rdata;

  // icb rule, command held while stalled
  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    icb_cmd_valid && !icb_cmd_ready |=>
      icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_len))
    else $error("icb command changed while stalled");

endmodule

// ==== verilog/kernel_loader.sv ====
`timescale 1ns/100ps

module kernel_loader import kl_pkg::*; #(
  parameter int SIZE      = 16,  // array edge, power of two 4..16
  parameter int BUS_WIDTH = 32   // icb data, 32 or 64
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   init_cfg,
  input  kl_cfg_t                cfg,
  output logic                   load_weight_req,
  input  logic                   load_weight_granted,
  input  logic                   send_weight_trigger,
  // icb master, read only
  output logic                   icb_cmd_valid,
  input  logic                   icb_cmd_ready,
  output logic [reg_width-1:0]   icb_cmd_addr,
  output logic [icb_len_w-1:0]   icb_cmd_len,
  input  logic                   icb_rsp_valid,
  output logic                   icb_rsp_ready,
  input  logic [BUS_WIDTH-1:0]   icb_rsp_rdata,
  // to systolic array
  output logic                   weight_row_valid,
  output logic [SIZE*byte_w-1:0] weight_out,
  output logic                   weight_sending_done,
  output logic                   weight_data_valid
);

  logic                    cfg_strobe;
  tile_geom_t              geom;
  logic [reg_width-1:0]    stride;
  logic [reg_width-1:0]    base;
  logic [byte_w-1:0]       zero_point;
  tile_job_t               job;
  logic                    load_start;
  logic                    tile_loaded;
  logic                    send_start;
  logic                    send_done;
  logic                    wr_en;
  logic [$clog2(SIZE)-1:0] wr_col;
  logic [$clog2(SIZE)-1:0] wr_row;
  logic [BUS_WIDTH-1:0]    wr_data;

  tile_geometry #(.SIZE(SIZE)) u_geom (
    .clk, .rst_n, .init_cfg(cfg_strobe), .cfg_in(cfg),
    .geom, .stride, .base, .zero_point
  );

  tile_sequencer #(.SIZE(SIZE)) u_seq (
    .clk, .rst_n, .init_cfg, .geom, .base, .stride,
    .load_weight_granted, .send_weight_trigger, .tile_loaded, .send_done,
    .cfg_strobe, .job, .load_start, .send_start,
    .load_weight_req, .weight_data_valid, .weight_sending_done
  );

  icb_column_reader #(.SIZE(SIZE), .BUS_WIDTH(BUS_WIDTH)) u_rd (
    .clk, .rst_n, .load_start, .job, .stride,
    .icb_cmd_valid, .icb_cmd_ready, .icb_cmd_addr, .icb_cmd_len,
    .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata,
    .tile_loaded, .wr_en, .wr_col, .wr_row, .wr_data
  );

  weight_tile_buffer #(.SIZE(SIZE), .BUS_WIDTH(BUS_WIDTH)) u_buf (
    .clk, .rst_n, .wr_en, .wr_col, .wr_row, .wr_data, .zero_point, .job,
    .send_start, .weight_row_valid, .weight_out, .send_done
  );

endmodule

// ==== verilog/kl_pkg.sv ====
package kl_pkg;

  // ======================================
  // widths
  // ======================================
  localparam int reg_width = 32;  // config words, addresses
  localparam int byte_w    = 8;   // one int8 weight
  localparam int icb_len_w = 4;   // icb burst length field, beats - 1

  // ======================================
  // loader states
  // ======================================
  typedef enum logic [1:0] {
    KL_IDLE = 2'd0,  // waiting for init_cfg
    KL_CFG  = 2'd1,  // tile set up, waiting for grant
    KL_LOAD = 2'd2,  // bursts in flight
    KL_SEND = 2'd3   // tile held, rows going out
  } kl_state_t;

  // configuration as sampled on init_cfg
  typedef struct packed {
    logic [reg_width-1:0] k;           // ia rows, sets repeat count
    logic [reg_width-1:0] n;           // weight rows
    logic [reg_width-1:0] m;           // weight columns
    logic [reg_width-1:0] zero_point;  // only low byte used
    logic [reg_width-1:0] col_stride;  // bytes between columns
    logic [reg_width-1:0] base;        // address of column 0
  } kl_cfg_t;

  // derived tiling
  typedef struct packed {
    logic [reg_width-1:0] row_tiles;  // ceil(n/SIZE)
    logic [reg_width-1:0] col_tiles;  // ceil(m/SIZE)
    logic [reg_width-1:0] loops;      // ceil(k/SIZE)
    logic [reg_width-1:0] last_rows;  // valid rows, last row tile
    logic [reg_width-1:0] last_cols;  // valid cols, last column tile
  } tile_geom_t;

  // one tile to load and send
  typedef struct packed {
    logic [reg_width-1:0] addr;  // first byte of column 0
    logic [15:0]          rows;  // valid rows
    logic [15:0]          cols;  // valid columns
  } tile_job_t;

endpackage

// ==== verilog/tile_geometry.sv ====
`timescale 1ns/100ps

module tile_geometry import kl_pkg::*; #(
  parameter int SIZE = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 init_cfg,    // already qualified by idle
  input  kl_cfg_t              cfg_in,
  output tile_geom_t           geom,
  output logic [reg_width-1:0] stride,
  output logic [reg_width-1:0] base,
  output logic [byte_w-1:0]    zero_point
);

  localparam int                   lg_size = $clog2(SIZE);
  localparam logic [reg_width-1:0] size_w  = reg_width'(SIZE);
  localparam logic [reg_width-1:0] size_m1 = reg_width'(SIZE - 1);

  logic [reg_width-1:0] row_tiles_c;
  logic [reg_width-1:0] col_tiles_c;
  logic [reg_width-1:0] loops_c;
  logic [reg_width-1:0] row_rem_c;  // padding rows in last row tile
  logic [reg_width-1:0] col_rem_c;  // padding cols in last column tile

  // ceil(x/SIZE) as add then shift
  assign row_tiles_c = (cfg_in.n + size_m1) >> lg_size;
  assign col_tiles_c = (cfg_in.m + size_m1) >> lg_size;
  assign loops_c     = (cfg_in.k + size_m1) >> lg_size;

  // rounded-up size minus real size
  assign row_rem_c = (row_tiles_c << lg_size) - cfg_in.n;
  assign col_rem_c = (col_tiles_c << lg_size) - cfg_in.m;

  // no state test here, sequencer gates init_cfg
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      geom       <= '0;
      stride     <= '0;
      base       <= '0;
      zero_point <= '0;
    end else if (init_cfg) begin
      geom.row_tiles <= row_tiles_c;
      geom.col_tiles <= col_tiles_c;
      geom.loops     <= loops_c;
      geom.last_rows <= size_w - row_rem_c;  // 1..SIZE
      geom.last_cols <= size_w - col_rem_c;
      stride         <= cfg_in.col_stride;
      base           <= cfg_in.base;
      zero_point     <= cfg_in.zero_point[byte_w-1:0];  // low byte only
    end
  end

endmodule

// ==== verilog/tile_sequencer.sv ====
`timescale 1ns/100ps

module tile_sequencer import kl_pkg::*; #(
  parameter int SIZE = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 init_cfg,
  input  tile_geom_t           geom,
  input  logic [reg_width-1:0] base,
  input  logic [reg_width-1:0] stride,
  input  logic                 load_weight_granted,
  input  logic                 send_weight_trigger,
  input  logic                 tile_loaded,
  input  logic                 send_done,
  output logic                 cfg_strobe,   // init_cfg taken in idle
  output tile_job_t            job,
  output logic                 load_start,
  output logic                 send_start,
  output logic                 load_weight_req,
  output logic                 weight_data_valid,
  output logic                 weight_sending_done
);

  localparam int                   lg_size = $clog2(SIZE);
  localparam logic [reg_width-1:0] size_w  = reg_width'(SIZE);
  localparam logic [15:0]          size_16 = 16'(SIZE);

  kl_state_t            state;
  logic [reg_width-1:0] row_idx;    // inner index
  logic [reg_width-1:0] col_idx;
  logic [reg_width-1:0] loop_cnt;   // outer repeat
  logic [reg_width-1:0] tile_addr;
  logic [reg_width-1:0] col_base;   // addr of row tile 0 in this column tile
  logic [reg_width-1:0] col_step;   // SIZE columns worth of stride
  logic                 last_row;
  logic                 last_col;
  logic                 last_loop;
  logic                 last_tile;
  logic                 cfg_first;  // first cycle after init_cfg

  // ======================================
  // strobes and flags
  // ======================================
  assign cfg_strobe = init_cfg && (state == KL_IDLE);
  assign cfg_first  = (state == KL_CFG) && !load_weight_req;
  assign load_start = (state == KL_CFG) && load_weight_req && load_weight_granted;
  assign send_start = (state == KL_SEND) && weight_data_valid && send_weight_trigger;

  assign weight_sending_done = send_done;  // straight from buffer

  assign last_row  = (row_idx == geom.row_tiles - 1);
  assign last_col  = (col_idx == geom.col_tiles - 1);
  assign last_loop = (loop_cnt == geom.loops - 1);
  assign last_tile = last_row && last_col && last_loop;

  assign col_step = stride << lg_size;  // no multiplier

  // current tile, full except at the matrix edge
  assign job.addr = tile_addr;
  assign job.rows = last_row ? geom.last_rows[15:0] : size_16;
  assign job.cols = last_col ? geom.last_cols[15:0] : size_16;

  // ======================================
  // state machine
  // ======================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= KL_IDLE;
    end else begin
      case (state)
        KL_IDLE: if (cfg_strobe) state <= KL_CFG;
        KL_CFG:  if (load_start) state <= KL_LOAD;
        KL_LOAD: if (tile_loaded) state <= KL_SEND;
        KL_SEND: if (send_done) state <= last_tile ? KL_IDLE : KL_CFG;
        default: state <= KL_IDLE;
      endcase
    end
  end

  // ======================================
  // tile walk: row tile, column tile, loop
  // ======================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_idx   <= '0;
      col_idx   <= '0;
      loop_cnt  <= '0;
      tile_addr <= '0;
      col_base  <= '0;
    end else if (cfg_strobe) begin
      row_idx  <= '0;
      col_idx  <= '0;
      loop_cnt <= '0;
    end else if (cfg_first) begin
      tile_addr <= base;  // base registered one cycle earlier
      col_base  <= base;
    end else if ((state == KL_SEND) && send_done) begin
      if (!last_row) begin
        row_idx   <= row_idx + 1;
        tile_addr <= tile_addr + size_w;  // next SIZE bytes down the column
      end else begin
        row_idx <= '0;
        if (!last_col) begin
          col_idx   <= col_idx + 1;
          col_base  <= col_base + col_step;
          tile_addr <= col_base + col_step;
        end else begin
          col_idx   <= '0;
          col_base  <= base;  // whole set again
          tile_addr <= base;
          loop_cnt  <= last_loop ? '0 : loop_cnt + 1;
        end
      end
    end
  end

  // ======================================
  // request / data valid handshakes
  // ======================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_weight_req <= 1'b0;
    end else if (load_weight_granted) begin
      load_weight_req <= 1'b0;  // drops the cycle after grant
    end else if (cfg_first) begin
      load_weight_req <= 1'b1;
    end else if ((state == KL_SEND) && send_done && !last_tile) begin
      load_weight_req <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_data_valid <= 1'b0;
    end else if ((state == KL_LOAD) && tile_loaded) begin
      weight_data_valid <= 1'b1;  // cycle after last beat
    end else if (send_start) begin
      weight_data_valid <= 1'b0;
    end
  end

  // trigger only counts with a full tile waiting
  a_trigger_needs_tile: assert property (@(posedge clk) disable iff (!rst_n)
    send_weight_trigger |-> weight_data_valid && (state == KL_SEND))
    else $error("send_weight_trigger with no tile loaded");

endmodule

// ==== verilog/weight_tile_buffer.sv ====
`timescale 1ns/100ps

module weight_tile_buffer import kl_pkg::*; #(
  parameter int SIZE      = 16,
  parameter int BUS_WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  logic [$clog2(SIZE)-1:0]  wr_col,
  input  logic [$clog2(SIZE)-1:0]  wr_row,
  input  logic [BUS_WIDTH-1:0]     wr_data,
  input  logic [byte_w-1:0]        zero_point,
  input  tile_job_t                job,
  input  logic                     send_start,
  output logic                     weight_row_valid,
  output logic [SIZE*byte_w-1:0]   weight_out,   // lane i at [i*8 +: 8]
  output logic                     send_done
);

  localparam int idx_w = $clog2(SIZE);
  localparam int bpb   = BUS_WIDTH / byte_w;

  logic signed [byte_w-1:0] tile_mem [SIZE][SIZE];  // [column][row]
  logic [idx_w-1:0]         row_idx;                // row on the output now
  logic                     row_in;                 // row inside valid rows

  // ======================================
  // fill, zero point added on the way in
  // ======================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < bpb; b++) begin
        if (int'(wr_row) + b < SIZE) begin  // beat wider than tile
          // 8-bit add, wraps
          tile_mem[wr_col][idx_w'(int'(wr_row) + b)] <=
            wr_data[b*byte_w +: byte_w] + zero_point;
        end
      end
    end
  end

  // ======================================
  // drain, last row first
  // ======================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_row_valid <= 1'b0;
      row_idx          <= '0;
      send_done        <= 1'b0;
    end else begin
      send_done <= 1'b0;  // single pulse
      if (send_start) begin
        weight_row_valid <= 1'b1;
        row_idx          <= idx_w'(SIZE - 1);
      end else if (weight_row_valid) begin
        if (row_idx == '0) begin
          weight_row_valid <= 1'b0;
          send_done        <= 1'b1;  // SIZE+1 after send_start
        end else begin
          row_idx <= row_idx - 1'b1;
        end
      end
    end
  end

  assign row_in = weight_row_valid && (16'(row_idx) < job.rows);

  // padding rows and lanes go out as zero
  for (genvar i = 0; i < SIZE; i++) begin : gen_lane
    assign weight_out[i*byte_w +: byte_w] =
      (row_in && (16'(i) < job.cols)) ? tile_mem[i][row_idx] : '0;
  end

  // exactly SIZE rows per tile
  a_row_burst: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(weight_row_valid) |-> weight_row_valid [*SIZE] ##1 !weight_row_valid)
    else $error("weight_row_valid burst length is not SIZE");

endmodule
